//--- hdl/vlsu_pkg.sv
//----------------------------------------------------------
// shared widths, operation and lmul codes, element widths
// and the register group union of the vector load/store unit
//----------------------------------------------------------
package vlsu_pkg;

    // four 32-bit banks make one 128-bit beat
    localparam int NUM_BANKS = 4;
    localparam int BANK_W    = 32;
    localparam int BEAT_W    = NUM_BANKS * BANK_W;

    // largest group is lmul 4, so four beats
    localparam int MAX_BEATS = 4;
    localparam int VEC_W     = MAX_BEATS * BEAT_W;

    localparam int ADDR_W    = 12;
    localparam int STRIDE_W  = 6;

    // codes 10 to 15 are never listed and count as no operation
    typedef enum logic [3:0] {
        OP_NONE   = 4'd0,
        OP_VLE8   = 4'd1,
        OP_VLE16  = 4'd2,
        OP_VLE32  = 4'd3,
        OP_VLSE8  = 4'd4,
        OP_VLSE16 = 4'd5,
        OP_VLSE32 = 4'd6,
        OP_VSE8   = 4'd7,
        OP_VSE16  = 4'd8,
        OP_VSE32  = 4'd9
    } lsu_op_e;

    // any other lmul value falls back to a single beat
    typedef enum logic [2:0] {
        LMUL_1 = 3'd0,
        LMUL_2 = 3'd1,
        LMUL_4 = 3'd2
    } lmul_e;

    typedef enum logic [1:0] {
        EW_8  = 2'd0,
        EW_16 = 2'd1,
        EW_32 = 2'd2
    } elem_w_e;

    // one register group, seen as elements or as memory beats
    typedef union packed {
        logic [VEC_W/8-1:0][7:0]            b;
        logic [VEC_W/16-1:0][15:0]          h;
        logic [VEC_W/32-1:0][31:0]          w;
        logic [MAX_BEATS-1:0][BEAT_W-1:0]   beat;
    } vec_u;

endpackage

//--- hdl/lsu_seq_if.sv
//----------------------------------------------------------
// sequencing state shared by the sequencer and datapath
//----------------------------------------------------------
interface lsu_seq_if (
    input logic clk
);

    // beat being addressed and the last beat index of the transfer
    logic [$clog2(vlsu_pkg::MAX_BEATS)-1:0] beat;
    logic [$clog2(vlsu_pkg::MAX_BEATS)-1:0] nbeats;
    logic                                   addr_phase;
    logic                                   is_store;

    // load data strobe, one cycle behind the address phase
    logic                                   cap_valid;
    logic [$clog2(vlsu_pkg::MAX_BEATS)-1:0] cap_beat;
    logic                                   cap_last;

    vlsu_pkg::elem_w_e                      ew;
    logic [vlsu_pkg::STRIDE_W-1:0]          stride_eff;

    modport seq (
        output beat, nbeats, addr_phase, is_store,
        output cap_valid, cap_beat, cap_last, ew, stride_eff
    );

    modport drv (
        input clk, beat, nbeats, addr_phase, is_store, cap_valid
    );

    modport asm (
        input cap_valid, cap_beat, cap_last, nbeats, ew, stride_eff
    );

endinterface

//--- hdl/lsu_sequencer.sv
//----------------------------------------------------------
// operation decode, beat counter, phase and capture strobes
//----------------------------------------------------------
module lsu_sequencer (
    input  logic                          clk,
    input  logic                          nrst,
    input  vlsu_pkg::lsu_op_e             op,
    input  vlsu_pkg::lmul_e               lmul,
    input  logic [vlsu_pkg::STRIDE_W-1:0] stride,
    lsu_seq_if.seq                        seq,
    output logic                          s_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ACTIVE,
        S_WAIT
    } state_e;

    state_e            state;
    vlsu_pkg::lsu_op_e op_q;
    logic              dec_kept;
    logic              dec_store;
    logic              dec_strided;
    logic [1:0]        dec_nbeats;
    vlsu_pkg::elem_w_e dec_ew;
    logic              start;

    // strided stores were never implemented, their codes do nothing
    assign dec_kept    = op inside {[vlsu_pkg::OP_VLE8:vlsu_pkg::OP_VSE32]};
    assign dec_store   = op inside {[vlsu_pkg::OP_VSE8:vlsu_pkg::OP_VSE32]};
    assign dec_strided = op inside {[vlsu_pkg::OP_VLSE8:vlsu_pkg::OP_VLSE32]};
    assign start       = (state == S_IDLE) && dec_kept;

    always_comb begin
        // element width comes from the op code alone
        case (op)
            vlsu_pkg::OP_VLE16, vlsu_pkg::OP_VLSE16, vlsu_pkg::OP_VSE16: dec_ew = vlsu_pkg::EW_16;
            vlsu_pkg::OP_VLE32, vlsu_pkg::OP_VLSE32, vlsu_pkg::OP_VSE32: dec_ew = vlsu_pkg::EW_32;
            default: dec_ew = vlsu_pkg::EW_8;
        endcase
        // beats minus one, reserved lmul means one beat
        case (lmul)
            vlsu_pkg::LMUL_2: dec_nbeats = 2'd1;
            vlsu_pkg::LMUL_4: dec_nbeats = 2'd3;
            default:          dec_nbeats = 2'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state          <= S_IDLE;
            seq.beat       <= '0;
            seq.nbeats     <= '0;
            seq.addr_phase <= 1'b0;
            seq.is_store   <= 1'b0;
            seq.cap_valid  <= 1'b0;
            seq.cap_beat   <= '0;
            seq.cap_last   <= 1'b0;
            seq.ew         <= vlsu_pkg::EW_8;
            seq.stride_eff <= 6'd1;
            s_done         <= 1'b0;
        end else begin
            s_done        <= 1'b0;
            // read data shows up one cycle after its row, loads only
            seq.cap_valid <= seq.addr_phase && !seq.is_store;
            seq.cap_beat  <= seq.beat;
            seq.cap_last  <= seq.addr_phase && !seq.is_store && (seq.beat == seq.nbeats);
            case (state)
                S_IDLE: begin
                    if (dec_kept) begin
                        state          <= S_ACTIVE;
                        seq.addr_phase <= 1'b1;
                        seq.beat       <= '0;
                        seq.nbeats     <= dec_nbeats;
                        seq.is_store   <= dec_store;
                        seq.ew         <= dec_ew;
                        // unit stride and stride 0 both gather every element
                        seq.stride_eff <= (dec_strided && stride != '0) ? stride : 6'd1;
                    end
                end
                S_ACTIVE: begin
                    if (seq.beat == seq.nbeats) begin
                        seq.addr_phase <= 1'b0;
                        s_done         <= seq.is_store;
                        state          <= S_WAIT;
                    end else begin
                        seq.beat <= seq.beat + 1'b1;
                    end
                end
                default: begin
                    // caller must drop the op before the next one
                    if (!dec_kept) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // op seen at the start, held for the active check
    always_ff @(posedge clk) begin
        if (start) begin
            op_q <= op;
        end
    end

    a_op_stable: assert property (@(posedge clk) disable iff (!nrst)
        (state == S_ACTIVE) |-> (op == op_q));

    // lmul must be a known code when a transfer starts
    a_lmul_start: assert property (@(posedge clk) disable iff (!nrst)
        start |-> !$isunknown(lmul));

    a_done_phase: assert property (@(posedge clk) disable iff (!nrst)
        !(s_done && seq.addr_phase));

endmodule

//--- hdl/bank_driver.sv
//----------------------------------------------------------
// bank row address, store beat split and write enable
//----------------------------------------------------------
module bank_driver (
    input  logic [vlsu_pkg::ADDR_W-1:0] address,
    input  logic [vlsu_pkg::VEC_W-1:0]  s_data,
    lsu_seq_if.drv                      drv,
    output logic [vlsu_pkg::ADDR_W-1:0] bank_addr,
    output logic [vlsu_pkg::BANK_W-1:0] wr_data0,
    output logic [vlsu_pkg::BANK_W-1:0] wr_data1,
    output logic [vlsu_pkg::BANK_W-1:0] wr_data2,
    output logic [vlsu_pkg::BANK_W-1:0] wr_data3,
    output logic                        bank_we
);

    vlsu_pkg::vec_u                                          store_vec;
    logic [vlsu_pkg::NUM_BANKS-1:0][vlsu_pkg::BANK_W-1:0]    store_words;

    // all four banks share one row, beat b sits at base plus b
    assign bank_addr = address
        + {{(vlsu_pkg::ADDR_W - $bits(drv.beat)){1'b0}}, drv.beat};

    // pick the current beat of the group
    assign store_vec   = s_data;
    assign store_words = store_vec.beat[drv.beat];

    // word 0 is the least significant, bank k holds word k
    assign wr_data0 = store_words[0];
    assign wr_data1 = store_words[1];
    assign wr_data2 = store_words[2];
    assign wr_data3 = store_words[3];

    assign bank_we = drv.addr_phase && drv.is_store;

    // writes and load captures never overlap
    a_we_not_load: assert property (@(posedge drv.clk)
        bank_we |-> !drv.cap_valid);

endmodule

//--- hdl/load_assembler.sv
//----------------------------------------------------------
// load beat capture, stride gather and load result register
//----------------------------------------------------------
module load_assembler (
    input  logic                        clk,
    input  logic                        nrst,
    input  logic [vlsu_pkg::BANK_W-1:0] rd_data0,
    input  logic [vlsu_pkg::BANK_W-1:0] rd_data1,
    input  logic [vlsu_pkg::BANK_W-1:0] rd_data2,
    input  logic [vlsu_pkg::BANK_W-1:0] rd_data3,
    lsu_seq_if.asm                      asm,
    output logic [vlsu_pkg::VEC_W-1:0]  l_data_out,
    output logic                        l_done
);

    vlsu_pkg::vec_u                grp;
    vlsu_pkg::vec_u                gathered;
    logic [vlsu_pkg::BEAT_W-1:0]   rd_beat;
    logic [2:0]                    beats_n;
    logic [6:0]                    nelem;
    logic                          gather_go;

    assign rd_beat = {rd_data3, rd_data2, rd_data1, rd_data0};

    // group register, beat 0 clears the upper beats
    always_ff @(posedge clk) begin
        if (asm.cap_valid) begin
            if (asm.cap_beat == '0) begin
                grp.beat[1] <= '0;
                grp.beat[2] <= '0;
                grp.beat[3] <= '0;
            end
            grp.beat[asm.cap_beat] <= rd_beat;
        end
    end

    // elements collected, 16 bytes or 8 halfwords or 4 words per beat
    assign beats_n = {1'b0, asm.nbeats} + 3'd1;

    always_comb begin
        case (asm.ew)
            vlsu_pkg::EW_8:  nelem = {beats_n, 4'b0};
            vlsu_pkg::EW_16: nelem = {1'b0, beats_n, 3'b0};
            default:         nelem = {2'b0, beats_n, 2'b0};
        endcase
    end

    // element j comes from element j*stride while that index is collected
    always_comb begin
        int unsigned idx;
        gathered = '0;
        case (asm.ew)
            vlsu_pkg::EW_8: begin
                for (int j = 0; j < vlsu_pkg::VEC_W / 8; j++) begin
                    idx = j * int'(asm.stride_eff);
                    if (idx < int'(nelem)) begin
                        gathered.b[j] = grp.b[idx[5:0]];
                    end
                end
            end
            vlsu_pkg::EW_16: begin
                for (int j = 0; j < vlsu_pkg::VEC_W / 16; j++) begin
                    idx = j * int'(asm.stride_eff);
                    if (idx < int'(nelem)) begin
                        gathered.h[j] = grp.h[idx[4:0]];
                    end
                end
            end
            default: begin
                for (int j = 0; j < vlsu_pkg::VEC_W / 32; j++) begin
                    idx = j * int'(asm.stride_eff);
                    if (idx < int'(nelem)) begin
                        gathered.w[j] = grp.w[idx[3:0]];
                    end
                end
            end
        endcase
    end

    // result lands one edge after the last beat is stored
    always_ff @(posedge clk) begin
        if (!nrst) begin
            gather_go  <= 1'b0;
            l_done     <= 1'b0;
            l_data_out <= '0;
        end else begin
            gather_go <= asm.cap_last;
            l_done    <= gather_go;
            if (gather_go) begin
                l_data_out <= gathered;
            end
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!nrst)
        l_done |=> !l_done);

endmodule

//--- hdl/vlsu_top.sv
//----------------------------------------------------------
// vector load/store unit top, sequencer plus bank driver
// plus load assembler
//----------------------------------------------------------
module vlsu_top (
    input  logic                          clk,
    input  logic                          nrst,
    input  vlsu_pkg::lsu_op_e             op,
    input  vlsu_pkg::lmul_e               lmul,
    input  logic [vlsu_pkg::STRIDE_W-1:0] stride,
    input  logic [vlsu_pkg::ADDR_W-1:0]   address,
    input  logic [vlsu_pkg::VEC_W-1:0]    s_data,
    input  logic [vlsu_pkg::BANK_W-1:0]   rd_data0,
    input  logic [vlsu_pkg::BANK_W-1:0]   rd_data1,
    input  logic [vlsu_pkg::BANK_W-1:0]   rd_data2,
    input  logic [vlsu_pkg::BANK_W-1:0]   rd_data3,
    output logic [vlsu_pkg::ADDR_W-1:0]   bank_addr,
    output logic [vlsu_pkg::BANK_W-1:0]   wr_data0,
    output logic [vlsu_pkg::BANK_W-1:0]   wr_data1,
    output logic [vlsu_pkg::BANK_W-1:0]   wr_data2,
    output logic [vlsu_pkg::BANK_W-1:0]   wr_data3,
    output logic                          bank_we,
    output logic                          s_done,
    output logic [vlsu_pkg::VEC_W-1:0]    l_data_out,
    output logic                          l_done
);

    // beat counter, phase and capture strobes
    lsu_seq_if i_seq_if (.clk(clk));

    lsu_sequencer i_lsu_sequencer (
        .clk    (clk),
        .nrst   (nrst),
        .op     (op),
        .lmul   (lmul),
        .stride (stride),
        .seq    (i_seq_if.seq),
        .s_done (s_done)
    );

    // row address and store words, same cycle as the beat
    bank_driver i_bank_driver (
        .address   (address),
        .s_data    (s_data),
        .drv       (i_seq_if.drv),
        .bank_addr (bank_addr),
        .wr_data0  (wr_data0),
        .wr_data1  (wr_data1),
        .wr_data2  (wr_data2),
        .wr_data3  (wr_data3),
        .bank_we   (bank_we)
    );

    load_assembler i_load_assembler (
        .clk        (clk),
        .nrst       (nrst),
        .rd_data0   (rd_data0),
        .rd_data1   (rd_data1),
        .rd_data2   (rd_data2),
        .rd_data3   (rd_data3),
        .asm        (i_seq_if.asm),
        .l_data_out (l_data_out),
        .l_done     (l_done)
    );

endmodule

//--- test/vlsu_tb.sv
//----------------------------------------------------------
// testbench for the vector load/store unit with bank memory
// model, lfsr stimulus, reference model and compare process
//----------------------------------------------------------
module vlsu_tb;

    // 9 loads, 9 stores with 9 read-backs, 18 strided, 6 reserved codes, 2 reserved lmul
    localparam int NUM_OPS  = 53;
    localparam int DONE_MAX = 20;

    logic                          clk;
    logic                          nrst;
    vlsu_pkg::lsu_op_e             op;
    vlsu_pkg::lmul_e               lmul;
    logic [vlsu_pkg::STRIDE_W-1:0] stride;
    logic [vlsu_pkg::ADDR_W-1:0]   address;
    logic [vlsu_pkg::VEC_W-1:0]    s_data;
    logic [vlsu_pkg::BANK_W-1:0]   rd_data0, rd_data1, rd_data2, rd_data3;
    logic [vlsu_pkg::ADDR_W-1:0]   bank_addr;
    logic [vlsu_pkg::BANK_W-1:0]   wr_data0, wr_data1, wr_data2, wr_data3;
    logic                          bank_we;
    logic                          s_done;
    logic [vlsu_pkg::VEC_W-1:0]    l_data_out;
    logic                          l_done;

    // one array per bank, same row for all four
    logic [31:0] mem0 [0:2**vlsu_pkg::ADDR_W-1];
    logic [31:0] mem1 [0:2**vlsu_pkg::ADDR_W-1];
    logic [31:0] mem2 [0:2**vlsu_pkg::ADDR_W-1];
    logic [31:0] mem3 [0:2**vlsu_pkg::ADDR_W-1];

    logic [31:0]  lfsr_state = 32'hfb65_254f;
    int           cyc        = 0;
    int           t0         = 0;
    int           cur_n      = 1;
    int           we_base    = 0;
    logic [11:0]  cur_addr   = '0;
    logic [511:0] cur_data   = '0;
    logic [511:0] exp_load   = '0;
    int           we_seen    = 0;
    int           s_seen     = 0;
    int           l_seen     = 0;
    int           drv_errors = 0;
    int           cmp_errors = 0;

    vlsu_top i_vlsu_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int nb);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nb; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [511:0] rand_vec();
        logic [511:0] v;
        for (int w = 0; w < 16; w++) begin
            v[w*32 +: 32] = rand_bits(32);
        end
        return v;
    endfunction

    function automatic int beats_of(input vlsu_pkg::lmul_e lm);
        case (lm)
            vlsu_pkg::LMUL_2: return 2;
            vlsu_pkg::LMUL_4: return 4;
            default:          return 1;
        endcase
    endfunction

    // ones over the first n beats
    function automatic logic [511:0] beat_mask(input int n);
        logic [511:0] m;
        m = '0;
        for (int b = 0; b < n; b++) begin
            m[b*128 +: 128] = '1;
        end
        return m;
    endfunction

    // four rows from the model, row a+b is beat b, bank 0 in the low word
    function automatic logic [511:0] read_rows(input logic [11:0] a);
        logic [511:0] r;
        logic [11:0]  row;
        for (int b = 0; b < 4; b++) begin
            row = a + 12'(b);
            r[b*128 +: 128] = {mem3[row], mem2[row], mem1[row], mem0[row]};
        end
        return r;
    endfunction

    function automatic logic [511:0] expected_load(input logic [511:0] rows,
                                                   input vlsu_pkg::lmul_e lm,
                                                   input vlsu_pkg::lsu_op_e code,
                                                   input logic [5:0] st);
        int           n;
        int           ew;
        int           s;
        int           nelem;
        logic [511:0] raw;
        logic [511:0] emask;
        logic [511:0] res;
        n = beats_of(lm);
        case (code)
            vlsu_pkg::OP_VLE16, vlsu_pkg::OP_VLSE16, vlsu_pkg::OP_VSE16: ew = 16;
            vlsu_pkg::OP_VLE32, vlsu_pkg::OP_VLSE32, vlsu_pkg::OP_VSE32: ew = 32;
            default: ew = 8;
        endcase
        // stride 0 and unit-stride loads take every element
        s = 1;
        if (code inside {[vlsu_pkg::OP_VLSE8:vlsu_pkg::OP_VLSE32]} && st != 6'd0) begin
            s = int'(st);
        end
        raw   = rows & beat_mask(n);
        nelem = n * 128 / ew;
        emask = (512'd1 << ew) - 512'd1;
        res   = '0;
        for (int j = 0; j < 512 / ew; j++) begin
            if (j * s < nelem) begin
                res = res | (((raw >> (j * s * ew)) & emask) << (j * ew));
            end
        end
        return res;
    endfunction

    task automatic fail_value(input string name, input logic [511:0] exp_v,
                              input logic [511:0] got_v);
        $display("[FAIL] %s exp %0h got %0h", name, exp_v, got_v);
        drv_errors++;
    endtask

    // drive one op, hold it to the done pulse, then check the pulse counts
    task automatic run_op(input vlsu_pkg::lsu_op_e code, input vlsu_pkg::lmul_e lm,
                          input logic [5:0] st, input logic [11:0] a,
                          input logic [511:0] sd, input logic [511:0] exp_val);
        int   n;
        int   waited;
        int   we0;
        int   s0;
        int   l0;
        logic st_op;
        logic seen;
        n     = beats_of(lm);
        st_op = code inside {[vlsu_pkg::OP_VSE8:vlsu_pkg::OP_VSE32]};
        we0   = we_seen;
        s0    = s_seen;
        l0    = l_seen;
        @(posedge clk);
        t0       = cyc;
        cur_n    = n;
        cur_addr = a;
        cur_data = sd;
        exp_load = exp_val;
        we_base  = we0;
        op      <= code;
        lmul    <= lm;
        stride  <= st;
        address <= a;
        s_data  <= sd;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < DONE_MAX) begin
            @(negedge clk);
            waited++;
            seen = st_op ? s_done : l_done;
        end
        if (!seen) begin
            $display("no done pulse within %0d cycles for op code %0d", DONE_MAX, code);
            drv_errors++;
        end
        @(posedge clk);
        op <= vlsu_pkg::OP_NONE;
        repeat (3) @(negedge clk);
        if (we_seen - we0 != (st_op ? n : 0)) begin
            $display("bank_we high for %0d cycles, expected %0d", we_seen - we0, st_op ? n : 0);
            drv_errors++;
        end
        if (s_seen - s0 != (st_op ? 1 : 0) || l_seen - l0 != (st_op ? 0 : 1)) begin
            $display("wrong number of done cycles for op code %0d", code);
            drv_errors++;
        end
    endtask

    task automatic run_load(input vlsu_pkg::lsu_op_e code, input vlsu_pkg::lmul_e lm,
                            input logic [5:0] st, input logic [11:0] a);
        run_op(code, lm, st, a, '0, expected_load(read_rows(a), lm, code, st));
    endtask

    task automatic hold_reserved(input logic [3:0] c);
        int total;
        total = we_seen + s_seen + l_seen;
        @(posedge clk);
        op <= vlsu_pkg::lsu_op_e'(c);
        repeat (10) @(negedge clk);
        @(posedge clk);
        op <= vlsu_pkg::OP_NONE;
        @(negedge clk);
        if (we_seen + s_seen + l_seen != total) begin
            $display("reserved code %0d raised bank_we, s_done or l_done", c);
            drv_errors++;
        end
    endtask

    // bank model with registered read
    initial begin
        for (int r = 0; r < 2**vlsu_pkg::ADDR_W; r++) begin
            mem0[r] = rand_bits(32);
            mem1[r] = rand_bits(32);
            mem2[r] = rand_bits(32);
            mem3[r] = rand_bits(32);
        end
        rd_data0 = '0;
        rd_data1 = '0;
        rd_data2 = '0;
        rd_data3 = '0;
        forever begin
            @(posedge clk);
            rd_data0 <= mem0[bank_addr];
            rd_data1 <= mem1[bank_addr];
            rd_data2 <= mem2[bank_addr];
            rd_data3 <= mem3[bank_addr];
            if (bank_we) begin
                mem0[bank_addr] <= wr_data0;
                mem1[bank_addr] <= wr_data1;
                mem2[bank_addr] <= wr_data2;
                mem3[bank_addr] <= wr_data3;
            end
        end
    end

    // k counts falling edges since the drive edge, E0 is one edge later
    always @(negedge clk) begin
        int          k;
        int          bi;
        logic [11:0] row;
        cyc = cyc + 1;
        k   = cyc - t0;
        if (nrst) begin
            if (bank_we) begin
                bi  = we_seen - we_base;
                row = cur_addr + 12'(bi);
                if (k != 2 + bi) begin
                    $display("bank_we high in cycle %0d of the store, expected %0d", k, 2 + bi);
                    cmp_errors++;
                end
                if (bank_addr !== row) begin
                    $display("[FAIL] bank_addr exp %h got %h", row, bank_addr);
                    cmp_errors++;
                end
                if (bi < 4) begin
                    if ({wr_data3, wr_data2, wr_data1, wr_data0} !== cur_data[bi*128 +: 128]) begin
                        $display("[FAIL] wr_data exp %h got %h", cur_data[bi*128 +: 128],
                                 {wr_data3, wr_data2, wr_data1, wr_data0});
                        cmp_errors++;
                    end
                end
                we_seen++;
            end
            if (s_done) begin
                s_seen++;
                if (k != cur_n + 2) begin
                    $display("s_done high in cycle %0d, expected %0d", k, cur_n + 2);
                    cmp_errors++;
                end
            end
            if (l_done) begin
                l_seen++;
                if (k != cur_n + 4) begin
                    $display("l_done high in cycle %0d, expected %0d", k, cur_n + 4);
                    cmp_errors++;
                end
                if (l_data_out !== exp_load) begin
                    $display("[FAIL] l_data_out exp %h got %h", exp_load, l_data_out);
                    cmp_errors++;
                end
            end
        end
    end

    initial begin
        #(NUM_OPS * 40 * 10);
        $display("timeout, operations did not finish within %0d cycles", NUM_OPS * 40);
        $display("driver errors %0d, compare errors %0d", drv_errors, cmp_errors);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic [11:0]     a;
        logic [511:0]    sd;
        logic [5:0]      st;
        vlsu_pkg::lmul_e lm;
        op      = vlsu_pkg::OP_NONE;
        lmul    = vlsu_pkg::LMUL_1;
        stride  = '0;
        address = '0;
        s_data  = '0;
        nrst    = 1'b0;
        repeat (2) @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);
        // outputs idle out of reset
        if (bank_we !== 1'b0) fail_value("bank_we", '0, bank_we);
        if (s_done !== 1'b0) fail_value("s_done", '0, s_done);
        if (l_done !== 1'b0) fail_value("l_done", '0, l_done);
        if (l_data_out !== '0) fail_value("l_data_out", '0, l_data_out);
        // unit-stride loads, every width and lmul, stride above 1 must be ignored
        for (int c = 1; c <= 3; c++) begin
            for (int m = 0; m < 3; m++) begin
                a  = 12'(rand_bits(12));
                st = 6'(rand_bits(5)) + 6'd2;
                run_load(vlsu_pkg::lsu_op_e'(4'(c)), vlsu_pkg::lmul_e'(3'(m)), st, a);
            end
        end
        // stores, each read back as 32-bit elements
        for (int c = 7; c <= 9; c++) begin
            for (int m = 0; m < 3; m++) begin
                a  = 12'(rand_bits(12));
                sd = rand_vec();
                lm = vlsu_pkg::lmul_e'(3'(m));
                run_op(vlsu_pkg::lsu_op_e'(4'(c)), lm, 6'd0, a, sd, '0);
                run_op(vlsu_pkg::OP_VLE32, lm, 6'd0, a, '0, sd & beat_mask(beats_of(lm)));
            end
        end
        // strided loads, 63 and 32 reach past most element counts
        for (int c = 4; c <= 6; c++) begin
            for (int k = 0; k < 6; k++) begin
                case (k)
                    0:       st = 6'd0;
                    1:       st = 6'd1;
                    2:       st = 6'd63;
                    3:       st = 6'd32;
                    default: st = 6'(rand_bits(6));
                endcase
                a  = 12'(rand_bits(12));
                lm = vlsu_pkg::lmul_e'(3'(rand_bits(2) % 3));
                run_load(vlsu_pkg::lsu_op_e'(4'(c)), lm, st, a);
            end
        end
        for (int c = 10; c <= 15; c++) begin
            hold_reserved(4'(c));
        end
        // reserved lmul codes move a single beat
        a = 12'(rand_bits(12));
        run_load(vlsu_pkg::OP_VLE32, vlsu_pkg::lmul_e'(3'd5), 6'd0, a);
        run_op(vlsu_pkg::OP_VSE16, vlsu_pkg::lmul_e'(3'd7), 6'd0, a, rand_vec(), '0);
        $display("driver errors %0d, compare errors %0d", drv_errors, cmp_errors);
        if (drv_errors == 0 && cmp_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- vlsu.f
hdl/vlsu_pkg.sv
hdl/lsu_seq_if.sv
hdl/lsu_sequencer.sv
hdl/bank_driver.sv
hdl/load_assembler.sv
hdl/vlsu_top.sv
test/vlsu_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = vlsu_tb
FILELIST = vlsu.f
OBJ_DIR  = obj_dir
PASS_MSG = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
